// File: spi_master.f
+incdir+design
design/spi_master_pkg.sv
design/spi_master_clkgen.sv
design/spi_master_tx.sv
design/spi_master_rx.sv
design/spi_master_ctrl.sv
design/spi_master_top.sv
sim/spi_master_sva.sv
sim/spi_master_checker.sv
sim/spi_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the spi master testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f spi_master.f --top-module spi_master_tb -o sim_spi_master

./obj_dir/sim_spi_master | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

// File: sim/spi_master_tb.sv
// ----------------------------------------------------------------------
// spi master testbench
// stimulus table, slave model and stream drivers around the DUT
// ----------------------------------------------------------------------
module spi_master_tb
  import spi_master_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    logic      op;
    spi_word_t cmd;
    hdr_len_t  cmd_len;
    spi_word_t addr;
    hdr_len_t  addr_len;
    data_len_t data_len;
    cs_mask_t  cs_mask;
    clk_div_t  clk_div;
    logic      stall;
  } row_t;

  localparam int num_rows = 7;

  logic         clk;
  logic         rstn;
  spi_req_t     req;
  logic         rd;
  logic         wr;
  clk_div_t     clk_div;
  logic         clk_div_valid;
  spi_word_t    tx_data;
  logic         tx_valid;
  logic         tx_ready;
  spi_word_t    rx_data;
  logic         rx_valid;
  logic         rx_ready;
  spi_pads_t    pads;
  logic         sdi;
  spi_phase_t   phase;
  logic         eot;
  logic [255:0] pattern;
  logic         row_end;
  logic         stall;
  int           chk_errors;
  int           limit;
  int           cycles;
  int           bit_idx;
  logic         slave_sclk_q;
  int           tx_delay;
  int           rx_delay;
  row_t         rows [num_rows];

  spi_master_top spi_master_top_i
  (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .req           ( req           ),
    .rd            ( rd            ),
    .wr            ( wr            ),
    .clk_div       ( clk_div       ),
    .clk_div_valid ( clk_div_valid ),
    .tx_data       ( tx_data       ),
    .tx_valid      ( tx_valid      ),
    .tx_ready      ( tx_ready      ),
    .rx_data       ( rx_data       ),
    .rx_valid      ( rx_valid      ),
    .rx_ready      ( rx_ready      ),
    .pads          ( pads          ),
    .sdi           ( sdi           ),
    .phase         ( phase         ),
    .eot           ( eot           )
  );

  spi_master_checker checker_i
  (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .req           ( req           ),
    .rd            ( rd            ),
    .wr            ( wr            ),
    .clk_div       ( clk_div       ),
    .clk_div_valid ( clk_div_valid ),
    .tx_data       ( tx_data       ),
    .tx_valid      ( tx_valid      ),
    .tx_ready      ( tx_ready      ),
    .rx_data       ( rx_data       ),
    .rx_valid      ( rx_valid      ),
    .rx_ready      ( rx_ready      ),
    .pads          ( pads          ),
    .phase         ( phase         ),
    .eot           ( eot           ),
    .pattern       ( pattern       ),
    .row_end       ( row_end       ),
    .errors        ( chk_errors    )
  );

  bind spi_master_top spi_master_sva spi_master_sva_i
  (
    .clk      ( clk      ),
    .rstn     ( rstn     ),
    .pads     ( pads     ),
    .phase    ( phase    ),
    .eot      ( eot      ),
    .rx_data  ( rx_data  ),
    .rx_valid ( rx_valid ),
    .rx_ready ( rx_ready )
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // op 0 is a write, 1 a read
  task automatic load_rows();
    rows[0] = '{1'b0, 32'hA500_0000, 6'd8,  32'h1234_5600, 6'd24, 16'd64, 4'b0001, 8'd1, 1'b0};
    rows[1] = '{1'b1, 32'h0B00_0000, 6'd8,  32'hBEEF_0000, 6'd16, 16'd80, 4'b0010, 8'd0, 1'b1};
    rows[2] = '{1'b0, 32'h0000_0000, 6'd0,  32'h0000_0000, 6'd0,  16'd70, 4'b1100, 8'd2, 1'b1};
    rows[3] = '{1'b1, 32'h9F3C_0000, 6'd16, 32'h0000_0000, 6'd0,  16'd32, 4'b0100, 8'd3, 1'b0};
    rows[4] = '{1'b0, 32'hDEAD_BEEF, 6'd32, 32'hC001_D00D, 6'd32, 16'd0,  4'b1000, 8'd0, 1'b0};
    rows[5] = '{1'b0, 32'h0000_0000, 6'd0,  32'h0000_0000, 6'd0,  16'd0,  4'b0001, 8'd1, 1'b0};
    rows[6] = '{1'b1, 32'h0000_0000, 6'd0,  32'h5A00_0000, 6'd8,  16'd7,  4'b1111, 8'd0, 1'b1};
  endtask

  task automatic run_row(input row_t r);
    logic got;
    @(negedge clk);
    req.cmd       = r.cmd;
    req.cmd_len   = r.cmd_len;
    req.addr      = r.addr;
    req.addr_len  = r.addr_len;
    req.data_len  = r.data_len;
    req.cs_mask   = r.cs_mask;
    clk_div       = r.clk_div;
    clk_div_valid = 1'b1;
    stall         = r.stall;
    for (int k = 0; k < 8; k++)
      pattern[32*k +: 32] = $urandom;
    @(negedge clk);
    clk_div_valid = 1'b0;
    if (r.op)
      rd = 1'b1;
    else
      wr = 1'b1;
    // an empty transfer ends in the start cycle
    @(posedge clk);
    got = eot;
    @(negedge clk);
    rd = 1'b0;
    wr = 1'b0;
    while (!got)
    begin
      @(posedge clk);
      got = eot;
    end
    @(negedge clk);
    while (rx_valid)
      @(negedge clk);
    row_end = 1'b1;
    @(negedge clk);
    row_end = 1'b0;
  endtask

  // slave drives the next pattern bit after each sclk fall
  always @(negedge clk)
  begin
    if (pads.csn == '1)
      bit_idx = 0;
    else if (slave_sclk_q && !pads.sclk)
      bit_idx++;
    slave_sclk_q = pads.sclk;
    sdi = pattern[bit_idx % 256];
  end

  always @(negedge clk)
  begin
    if (tx_valid)
    begin
      if (!tx_ready)
        tx_valid = 1'b0;
    end
    else if (tx_ready)
    begin
      if (tx_delay > 0)
        tx_delay--;
      else
      begin
        tx_data  = $urandom;
        tx_valid = 1'b1;
        tx_delay = stall ? int'($urandom % 8) : 0;
      end
    end
  end

  always @(negedge clk)
  begin
    if (rx_ready)
    begin
      if (!rx_valid)
        rx_ready = 1'b0;
    end
    else if (rx_valid)
    begin
      if (rx_delay > 0)
        rx_delay--;
      else
      begin
        rx_ready = 1'b1;
        rx_delay = stall ? int'($urandom % 8) : 0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout: no end of transfer after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(24898));
    rstn          = 1'b0;
    req           = '0;
    rd            = 1'b0;
    wr            = 1'b0;
    clk_div       = '0;
    clk_div_valid = 1'b0;
    tx_data       = '0;
    tx_valid      = 1'b0;
    rx_ready      = 1'b0;
    sdi           = 1'b0;
    pattern       = '0;
    row_end       = 1'b0;
    stall         = 1'b0;
    cycles        = 0;
    bit_idx       = 0;
    slave_sclk_q  = 1'b0;
    tx_delay      = 0;
    rx_delay      = 0;
    load_rows();
    limit = 200;
    for (int i = 0; i < num_rows; i++)
      limit += (int'(rows[i].cmd_len) + int'(rows[i].addr_len) + int'(rows[i].data_len))
               * 2 * (int'(rows[i].clk_div) + 1) + 64;

    repeat (3) @(negedge clk);
    rstn = 1'b1;
    repeat (2) @(negedge clk);

    for (int i = 0; i < num_rows; i++)
      run_row(rows[i]);

    repeat (4) @(negedge clk);
    $display("errors: checker %0d over %0d rows", chk_errors, num_rows);
    if (chk_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: sim/spi_master_checker.sv
// ----------------------------------------------------------------------
// spi master checker
// compares pads and streams against bits expected from the request
// ----------------------------------------------------------------------
module spi_master_checker
  import spi_master_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  spi_req_t     req,
  input  logic         rd,
  input  logic         wr,
  input  clk_div_t     clk_div,
  input  logic         clk_div_valid,
  input  spi_word_t    tx_data,
  input  logic         tx_valid,
  input  logic         tx_ready,
  input  spi_word_t    rx_data,
  input  logic         rx_valid,
  input  logic         rx_ready,
  input  spi_pads_t    pads,
  input  spi_phase_t   phase,
  input  logic         eot,
  input  logic [255:0] pattern,
  input  logic         row_end,
  output int           errors
);
  timeunit 1ns;
  timeprecision 1ps;

  logic      is_rd;
  logic      sclk_q;
  logic      pend_q;
  logic      seen_rst;
  int        rises;
  int        high_cnt;
  int        rx_words;
  clk_div_t  div;
  logic      cap [$];
  spi_word_t tx_words [$];

  initial errors = 0;

  task automatic flag_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // slave bits after the header, msb first, short word right-aligned
  function automatic spi_word_t rx_expect(input int w);
    spi_word_t v;
    int        hdr;
    int        last;
    v    = '0;
    hdr  = int'(req.cmd_len) + int'(req.addr_len);
    last = 32 * w + 32;
    if (last > int'(req.data_len))
      last = int'(req.data_len);
    for (int k = 32 * w; k < last; k++)
      v = {v[30:0], pattern[(hdr + k) % 256]};
    return v;
  endfunction

  // phase expected while bit n of the transfer is on the wire
  function automatic spi_phase_t phase_for_bit(input int n);
    spi_phase_t p;
    p = '0;
    if (n < int'(req.cmd_len))
      p.cmd = 1'b1;
    else if (n < int'(req.cmd_len) + int'(req.addr_len))
      p.addr = 1'b1;
    else if (is_rd)
      p.data_rx = 1'b1;
    else
      p.data_tx = 1'b1;
    return p;
  endfunction

  task automatic check_row();
    logic exp [$];
    int   total;
    total = int'(req.cmd_len) + int'(req.addr_len) + int'(req.data_len);
    if (rises != total)
      flag_error($sformatf("%0d sclk rises, expected %0d", rises, total));
    if (is_rd)
    begin
      if (rx_words != (int'(req.data_len) + 31) / 32)
        flag_error($sformatf("%0d rx words for %0d bits", rx_words, req.data_len));
    end
    else
    begin
      for (int i = 0; i < int'(req.cmd_len); i++)
        exp.push_back(req.cmd[31-i]);
      for (int i = 0; i < int'(req.addr_len); i++)
        exp.push_back(req.addr[31-i]);
      for (int i = 0; i < int'(req.data_len); i++)
        exp.push_back((i / 32 < tx_words.size()) ? tx_words[i/32][31 - i % 32] : 1'bx);
      for (int i = 0; i < exp.size() && i < cap.size(); i++)
        if (cap[i] !== exp[i])
          flag_error($sformatf("sdo bit %0d is %b, expected %b", i, cap[i], exp[i]));
    end
  endtask

  always @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      sclk_q   = 1'b0;
      pend_q   = 1'b0;
      seen_rst = 1'b0;
      high_cnt = 0;
      div      = '0;
    end
    else
    begin
      if (!seen_rst)
      begin
        seen_rst = 1'b1;
        if (pads.csn != '1 || pads.sclk || eot || tx_ready || rx_valid
            || phase != spi_phase_t'(5'b00001))
          flag_error("outputs not inactive after reset");
      end
      if (clk_div_valid)
        div = clk_div;
      if ((rd || wr) && phase.idle)
      begin
        is_rd    = rd;
        rises    = 0;
        rx_words = 0;
        cap.delete();
        tx_words.delete();
      end
      if (!phase.idle && pads.csn != ~req.cs_mask)
        flag_error($sformatf("csn %b with mask %b", pads.csn, req.cs_mask));
      if (phase.idle && pads.csn != '1)
        flag_error("csn low while idle");
      if (tx_valid && tx_ready)
        tx_words.push_back(tx_data);
      if (rx_valid && rx_ready)
      begin
        if (rx_data !== rx_expect(rx_words))
          flag_error($sformatf("rx word %0d is %h, expected %h",
                               rx_words, rx_data, rx_expect(rx_words)));
        rx_words++;
      end
      if (!sclk_q && pads.sclk)
      begin
        if (phase !== phase_for_bit(rises))
          flag_error($sformatf("phase %b at bit %0d, expected %b",
                               phase, rises, phase_for_bit(rises)));
        rises++;
        if (!is_rd)
          cap.push_back(pads.sdo);
        if (pend_q)
          flag_error("sclk rise while rx word pending");
      end
      if (pads.sclk)
        high_cnt++;
      else if (sclk_q)
      begin
        if (high_cnt != int'(div) + 1)
          flag_error($sformatf("sclk high %0d cycles, div %0d", high_cnt, div));
        high_cnt = 0;
      end
      if (tx_ready && pads.sclk)
        flag_error("sclk high while tx word awaited");
      pend_q = rx_valid && !rx_ready;
      sclk_q = pads.sclk;
      if (row_end)
        check_row();
    end
  end

endmodule

// File: sim/spi_master_sva.sv
// ----------------------------------------------------------------------
// spi master protocol assertions, bound to the top level
// ----------------------------------------------------------------------
module spi_master_sva
  import spi_master_pkg::*;
(
  input logic       clk,
  input logic       rstn,
  input spi_pads_t  pads,
  input spi_phase_t phase,
  input logic       eot,
  input spi_word_t  rx_data,
  input logic       rx_valid,
  input logic       rx_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  csn_idle_a: assert property (@(posedge clk) disable iff (!rstn)
    phase.idle |-> pads.csn == '1)
    else $error("chip select low while idle");

  eot_pulse_a: assert property (@(posedge clk) disable iff (!rstn)
    eot |=> !eot)
    else $error("eot high for two cycles");

  // word held until taken
  rx_stable_a: assert property (@(posedge clk) disable iff (!rstn)
    rx_valid && !rx_ready |=> $stable(rx_data))
    else $error("rx_data changed while pending");

  sclk_idle_a: assert property (@(posedge clk) disable iff (!rstn)
    phase.idle |-> !pads.sclk)
    else $error("sclk high while idle");

endmodule

// File: design/spi_master_top.sv
// ---------------------------------------------------------------------
// spi master top level
// controller, clock generator and both shifters
// ---------------------------------------------------------------------
module spi_master_top
(
  input  logic                      clk,
  input  logic                      rstn,
  input  spi_master_pkg::spi_req_t  req,
  input  logic                      rd,
  input  logic                      wr,
  input  spi_master_pkg::clk_div_t  clk_div,
  input  logic                      clk_div_valid,
  input  spi_master_pkg::spi_word_t tx_data,
  input  logic                      tx_valid,
  output logic                      tx_ready,
  output spi_master_pkg::spi_word_t rx_data,
  output logic                      rx_valid,
  input  logic                      rx_ready,
  output spi_master_pkg::spi_pads_t pads,
  input  logic                      sdi,
  output spi_master_pkg::spi_phase_t phase,
  output logic                      eot
);

  logic                      clock_en;
  logic                      sclk;
  logic                      rise;
  logic                      fall;
  logic                      tx_load;
  spi_master_pkg::spi_word_t tx_word;
  spi_master_pkg::bit_cnt_t  tx_bits;
  logic                      tx_word_valid;
  logic                      rx_load;
  spi_master_pkg::bit_cnt_t  rx_bits;
  logic                      tx_done;
  logic                      rx_done;
  logic                      tx_clk_en;
  logic                      rx_clk_en;
  logic                      sdo;
  spi_master_pkg::cs_mask_t  csn;

  spi_master_ctrl u_ctrl
  (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .req           ( req           ),
    .rd            ( rd            ),
    .wr            ( wr            ),
    .tx_done       ( tx_done       ),
    .rx_done       ( rx_done       ),
    .fall          ( fall          ),
    .tx_clk_en     ( tx_clk_en     ),
    .rx_clk_en     ( rx_clk_en     ),
    .clock_en      ( clock_en      ),
    .tx_load       ( tx_load       ),
    .tx_word       ( tx_word       ),
    .tx_bits       ( tx_bits       ),
    .tx_word_valid ( tx_word_valid ),
    .rx_load       ( rx_load       ),
    .rx_bits       ( rx_bits       ),
    .csn           ( csn           ),
    .phase         ( phase         ),
    .eot           ( eot           )
  );

  spi_master_clkgen u_clkgen
  (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .en            ( clock_en      ),
    .clk_div       ( clk_div       ),
    .clk_div_valid ( clk_div_valid ),
    .sclk          ( sclk          ),
    .rise          ( rise          ),
    .fall          ( fall          )
  );

  spi_master_tx u_tx
  (
    .clk        ( clk           ),
    .rstn       ( rstn          ),
    .load       ( tx_load       ),
    .word       ( tx_word       ),
    .bits       ( tx_bits       ),
    .word_valid ( tx_word_valid ),
    .fall       ( fall          ),
    .tx_data    ( tx_data       ),
    .tx_valid   ( tx_valid      ),
    .tx_ready   ( tx_ready      ),
    .sdo        ( sdo           ),
    .done       ( tx_done       ),
    .clk_en     ( tx_clk_en     )
  );

  spi_master_rx u_rx
  (
    .clk      ( clk       ),
    .rstn     ( rstn      ),
    .load     ( rx_load   ),
    .bits     ( rx_bits   ),
    .rise     ( rise      ),
    .sdi      ( sdi       ),
    .rx_data  ( rx_data   ),
    .rx_valid ( rx_valid  ),
    .rx_ready ( rx_ready  ),
    .done     ( rx_done   ),
    .clk_en   ( rx_clk_en )
  );

  // field order sclk, csn, sdo
  assign pads = {sclk, csn, sdo};

endmodule

// File: design/spi_master_ctrl.sv
// ---------------------------------------------------------------------
// spi transfer controller
// sequences cmd, addr and data phases and drives the chip selects
// ---------------------------------------------------------------------
module spi_master_ctrl
  import spi_master_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  spi_req_t   req,
  input  logic       rd,
  input  logic       wr,
  input  logic       tx_done,
  input  logic       rx_done,
  input  logic       fall,
  input  logic       tx_clk_en,
  input  logic       rx_clk_en,
  output logic       clock_en,
  output logic       tx_load,
  output spi_word_t  tx_word,
  output bit_cnt_t   tx_bits,
  output logic       tx_word_valid,
  output logic       rx_load,
  output bit_cnt_t   rx_bits,
  output cs_mask_t   csn,
  output spi_phase_t phase,
  output logic       eot
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  ctrl_state_t target;
  logic        is_rd_q;
  logic        rd_op;
  logic        advance;

  // first non-empty phase after cur, IDLE when nothing is left
  function automatic ctrl_state_t next_phase(input ctrl_state_t cur,
                                             input spi_req_t    r,
                                             input logic        rd_flag);
    ctrl_state_t nxt;
    nxt = IDLE;
    if ((cur == IDLE) && (r.cmd_len != '0))
      nxt = CMD;
    else if ((cur != ADDR) && (r.addr_len != '0))
      nxt = ADDR;
    else if (r.data_len != '0)
      nxt = rd_flag ? DATA_RX : DATA_TX;
    return nxt;
  endfunction

  assign rd_op  = (state_q == IDLE) ? rd : is_rd_q;
  assign target = next_phase(state_q, req, rd_op);

  // ------------------------------------------------------------------
  // next state and shifter loads
  // ------------------------------------------------------------------
  always_comb
  begin
    state_d       = state_q;
    advance       = 1'b0;
    clock_en      = 1'b0;
    eot           = 1'b0;
    tx_load       = 1'b0;
    tx_word       = '0;
    tx_bits       = '0;
    tx_word_valid = 1'b0;
    rx_load       = 1'b0;
    rx_bits       = '0;

    case (state_q)
      IDLE:
        advance = rd | wr;
      CMD, ADDR:
      begin
        clock_en = 1'b1;
        advance  = tx_done;
      end
      DATA_TX:
      begin
        clock_en = tx_clk_en & ~tx_done;
        if (tx_done)
        begin
          eot     = 1'b1;
          state_d = IDLE;
        end
      end
      DATA_RX:
      begin
        clock_en = rx_clk_en;
        if (rx_done)
          state_d = WAIT_EDGE;
      end
      WAIT_EDGE:
      begin
        // last high phase still has to come down
        if (fall)
        begin
          eot     = 1'b1;
          state_d = IDLE;
        end
      end
      default:
        state_d = IDLE;
    endcase

    if (advance)
    begin
      state_d = target;
      case (target)
        CMD:
        begin
          tx_load       = 1'b1;
          tx_word       = req.cmd;
          tx_bits       = bit_cnt_t'(req.cmd_len);
          tx_word_valid = 1'b1;
        end
        ADDR:
        begin
          tx_load       = 1'b1;
          tx_word       = req.addr;
          tx_bits       = bit_cnt_t'(req.addr_len);
          tx_word_valid = 1'b1;
        end
        DATA_TX:
        begin
          // words come from the tx stream
          tx_load = 1'b1;
          tx_bits = req.data_len;
        end
        DATA_RX:
        begin
          rx_load = 1'b1;
          rx_bits = req.data_len;
        end
        default:
          eot = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      state_q <= IDLE;
      is_rd_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if ((state_q == IDLE) && (rd || wr))
        is_rd_q <= rd;
    end
  end

  // ------------------------------------------------------------------
  // status and chip selects
  // ------------------------------------------------------------------
  always_comb
  begin
    phase         = '0;
    phase.idle    = (state_q == IDLE);
    phase.cmd     = (state_q == CMD);
    phase.addr    = (state_q == ADDR);
    phase.data_tx = (state_q == DATA_TX);
    phase.data_rx = (state_q == DATA_RX) || (state_q == WAIT_EDGE);
  end

  assign csn = (state_q == IDLE) ? '1 : ~req.cs_mask;

endmodule

// File: design/spi_master_rx.sv
// ---------------------------------------------------------------------
// spi receive shifter
// samples sdi on rise and hands out words on the rx stream
// ---------------------------------------------------------------------
`include "spi_master_consts.svh"

module spi_master_rx
  import spi_master_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      load,
  input  bit_cnt_t  bits,
  input  logic      rise,
  input  logic      sdi,
  output spi_word_t rx_data,
  output logic      rx_valid,
  input  logic      rx_ready,
  output logic      done,
  output logic      clk_en
);

  localparam int unsigned pos_w = $clog2(`SPI_WORD_W);

  spi_word_t        sr_q;
  bit_cnt_t         cnt_q;
  logic [pos_w-1:0] pos_q;
  logic             valid_q;
  logic             sample;
  logic             last;

  assign sample   = rise && (cnt_q != '0);
  assign last     = (cnt_q == bit_cnt_t'(1));
  assign done     = sample && last;
  assign rx_data  = sr_q;
  assign rx_valid = valid_q;
  // no new rise while a word is pending
  assign clk_en   = ~(valid_q & ~rx_ready);

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      cnt_q   <= '0;
      pos_q   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (valid_q && rx_ready)
        valid_q <= 1'b0;

      if (load)
      begin
        cnt_q <= bits;
        pos_q <= '0;
      end
      else if (sample)
      begin
        cnt_q <= cnt_q - 1'b1;
        pos_q <= pos_q + 1'b1;
        if (last || (pos_q == '1))
          valid_q <= 1'b1;
      end
    end
  end

  // first bit of a word clears the rest, so a short last word is right-aligned
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (pos_q == '0)
        sr_q <= spi_word_t'(sdi);
      else
        sr_q <= {sr_q[`SPI_WORD_W-2:0], sdi};
    end
  end

endmodule

// File: design/spi_master_tx.sv
// ---------------------------------------------------------------------
// spi transmit shifter
// sends msb first, refills from the tx stream every 32 data bits
// ---------------------------------------------------------------------
`include "spi_master_consts.svh"

module spi_master_tx
  import spi_master_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      load,
  input  spi_word_t word,
  input  bit_cnt_t  bits,
  input  logic      word_valid,
  input  logic      fall,
  input  spi_word_t tx_data,
  input  logic      tx_valid,
  output logic      tx_ready,
  output logic      sdo,
  output logic      done,
  output logic      clk_en
);

  localparam int unsigned pos_w = $clog2(`SPI_WORD_W);

  spi_word_t        sr_q;
  bit_cnt_t         cnt_q;
  logic [pos_w-1:0] pos_q;
  logic             stream_q;
  logic             wait_q;
  logic             shift;
  logic             last;

  assign shift    = fall && !wait_q && (cnt_q != '0);
  assign last     = (cnt_q == bit_cnt_t'(1));
  assign done     = shift && last;
  assign sdo      = sr_q[`SPI_WORD_W-1];
  assign tx_ready = wait_q;
  // hold sclk low until the next word is in
  assign clk_en   = ~wait_q;

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      cnt_q    <= '0;
      pos_q    <= '0;
      stream_q <= 1'b0;
      wait_q   <= 1'b0;
    end
    else if (load)
    begin
      cnt_q    <= bits;
      pos_q    <= '0;
      stream_q <= ~word_valid;
      wait_q   <= ~word_valid;
    end
    else
    begin
      if (wait_q && tx_valid)
        wait_q <= 1'b0;

      if (shift)
      begin
        cnt_q <= cnt_q - 1'b1;
        pos_q <= pos_q + 1'b1;
        // word used up, more bits to go
        if (stream_q && !last && (pos_q == '1))
          wait_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load && word_valid)
      sr_q <= word;
    else if (wait_q && tx_valid)
      sr_q <= tx_data;
    else if (shift)
      sr_q <= {sr_q[`SPI_WORD_W-2:0], 1'b0};
  end

endmodule

// File: design/spi_master_clkgen.sv
// ---------------------------------------------------------------------
// spi serial clock generator
// divides clk into sclk with one-cycle rise and fall strobes
// ---------------------------------------------------------------------
module spi_master_clkgen
  import spi_master_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     en,
  input  clk_div_t clk_div,
  input  logic     clk_div_valid,
  output logic     sclk,
  output logic     rise,
  output logic     fall
);

  clk_div_t div_q;
  clk_div_t cnt_q;
  logic     sclk_q;
  logic     run;
  logic     tc;

  // a high phase, once started, always runs to its fall
  assign run  = en | sclk_q;
  assign tc   = run && (cnt_q == div_q);
  assign rise = tc & ~sclk_q;
  assign fall = tc & sclk_q;
  assign sclk = sclk_q;

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      div_q  <= '0;
      cnt_q  <= '0;
      sclk_q <= 1'b0;
    end
    else
    begin
      if (clk_div_valid)
        div_q <= clk_div;

      if (tc)
      begin
        cnt_q  <= '0;
        sclk_q <= ~sclk_q;
      end
      else if (run)
        cnt_q <= cnt_q + 1'b1;
      else
        cnt_q <= '0;
    end
  end

endmodule

// File: design/spi_master_pkg.sv
// ---------------------------------------------------------------------
// spi master types
// request and pad structs, phase status and controller states
// ---------------------------------------------------------------------
`include "spi_master_consts.svh"

package spi_master_pkg;

  typedef logic [`SPI_WORD_W-1:0]     spi_word_t;
  typedef logic [`SPI_HDR_LEN_W-1:0]  hdr_len_t;
  typedef logic [`SPI_DATA_LEN_W-1:0] data_len_t;
  typedef logic [`SPI_DIV_W-1:0]      clk_div_t;
  typedef logic [`SPI_NUM_CS-1:0]     cs_mask_t;
  typedef logic [`SPI_DATA_LEN_W-1:0] bit_cnt_t;

  // cmd and addr are left-aligned
  typedef struct packed {
    spi_word_t cmd;
    hdr_len_t  cmd_len;
    spi_word_t addr;
    hdr_len_t  addr_len;
    data_len_t data_len;
    cs_mask_t  cs_mask;
  } spi_req_t;

  typedef struct packed {
    logic     sclk;
    cs_mask_t csn;
    logic     sdo;
  } spi_pads_t;

  // one-hot, idle in bit 0
  typedef struct packed {
    logic data_rx;
    logic data_tx;
    logic addr;
    logic cmd;
    logic idle;
  } spi_phase_t;

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    ADDR,
    DATA_TX,
    DATA_RX,
    WAIT_EDGE
  } ctrl_state_t;

endpackage

// File: design/spi_master_consts.svh
// ---------------------------------------------------------------------
// spi master constants
// field widths shared by the package and the shifters
// ---------------------------------------------------------------------
`ifndef SPI_MASTER_CONSTS_SVH
`define SPI_MASTER_CONSTS_SVH

// data and header word
`define SPI_WORD_W 32

// command and address length fields
`define SPI_HDR_LEN_W 6

// data phase length in bits
`define SPI_DATA_LEN_W 16

`define SPI_DIV_W 8
`define SPI_NUM_CS 4

`endif
